// File: logic/dz_settings.svh
// DZ11 build settings
`ifndef DZ_SETTINGS_SVH
`define DZ_SETTINGS_SVH

// Clock, clear one-shot and serial timing
`define DZ_CLK_FREQ   25000000
`define DZ_CLR_US     15
`define DZ_BIT_CYCLES 16
`define DZ_LINES      8

// CSR fields
`define DZ_CSR_TRDY   15
`define DZ_CSR_TIE    14
`define DZ_CSR_SA     13
`define DZ_CSR_SAE    12
`define DZ_CSR_TLINE  10:8
`define DZ_CSR_RDONE  7
`define DZ_CSR_RIE    6
`define DZ_CSR_MSE    5
`define DZ_CSR_CLR    4
`define DZ_CSR_MAINT  3

// TCR fields
`define DZ_TCR_LIN    7:0
`define DZ_TCR_DTR    15:8

`endif

// File: logic/dzPkg.sv
// DZ11 shared types
`default_nettype none

`include "dz_settings.svh"

package dzPkg;

   ////////////////////////////////////////////////////////////////////////////
   // Register select
   ////////////////////////////////////////////////////////////////////////////

   // Word register offsets on the bus
   typedef enum logic [1:0]
   {
      regCsr  = 2'd0,
      regRbuf = 2'd1,
      regTcr  = 2'd2,
      regTdr  = 2'd3
   } dzAddr_t;

   ////////////////////////////////////////////////////////////////////////////
   // Line and word types
   ////////////////////////////////////////////////////////////////////////////

   // Line number, 0 to 7
   typedef logic [$clog2(`DZ_LINES)-1:0] dzLine_t;

   // One bit per line
   typedef logic [`DZ_LINES-1:0] dzLineMask_t;

   // Register word
   typedef logic [15:0] dzWord_t;

endpackage

`default_nettype wire

// File: logic/dzRegBus.sv
// DZ11 register write bus
`default_nettype none
`timescale 1ns/1ns

interface dzRegBus;
   import dzPkg::*;

   // Decoded one-cycle write strobes
   logic    csrWrite;
   logic    tcrWrite;
   logic    tdrWrite;

   // Byte lanes, valid with a strobe
   logic    loByte;
   logic    hiByte;

   // Device reset level from the bus adapter
   logic    devReset;

   // Write data
   dzWord_t data;

   // Address decoder side
   modport decoder (output csrWrite, tcrWrite, tdrWrite, loByte, hiByte,
                    devReset, data);

   // Register blocks only listen
   modport register (input csrWrite, tcrWrite, tdrWrite, loByte, hiByte,
                     devReset, data);

endinterface

`default_nettype wire

// File: logic/dzBusDecode.sv
// DZ11 register address decode
`default_nettype none
`timescale 1ns/1ns

module dzBusDecode (
   input  wire dzPkg::dzAddr_t  busAddr,
   input  wire logic            busWrite,
   input  wire logic            loByte,
   input  wire logic            hiByte,
   input  wire dzPkg::dzWord_t  dataIn,
   input  wire logic            devReset,
   input  wire dzPkg::dzWord_t  regCsr,
   input  wire dzPkg::dzWord_t  regTcr,
   output dzPkg::dzWord_t       dataOut,
   dzRegBus.decoder             regBus
);
   import dzPkg::*;

   ////////////////////////////////////////////////////////////////////////////
   // Write strobes
   ////////////////////////////////////////////////////////////////////////////

   // CSR and TCR offsets share names with the register ports here,
   // so those two go by their package names
   assign regBus.csrWrite = busWrite & (busAddr == dzPkg::regCsr);
   assign regBus.tcrWrite = busWrite & (busAddr == dzPkg::regTcr);
   assign regBus.tdrWrite = busWrite & (busAddr == regTdr);

   // RBUF offset is read only, writes fall on the floor

   // Lanes, data and device reset pass straight to the registers
   assign regBus.loByte   = loByte;
   assign regBus.hiByte   = hiByte;
   assign regBus.data     = dataIn;
   assign regBus.devReset = devReset;

   ////////////////////////////////////////////////////////////////////////////
   // Read mux
   ////////////////////////////////////////////////////////////////////////////

   always_comb
   begin
      dataOut = '0;
      case (busAddr)
         dzPkg::regCsr:
         begin
            dataOut = regCsr;
         end
         dzPkg::regTcr:
         begin
            dataOut = regTcr;
         end
         // No receiver, no modem status
         regRbuf,
         regTdr:
         begin
            dataOut = '0;
         end
      endcase
   end

endmodule

`default_nettype wire

// File: logic/dzTcr.sv
// DZ11 transmit control register
`default_nettype none
`timescale 1ns/1ns

`include "dz_settings.svh"

module dzTcr (
   input  wire logic      clk,
   input  wire logic      rst,
   dzRegBus.register      regBus,
   output dzPkg::dzWord_t regTcr
);
   import dzPkg::*;

   // Line enables in the low byte, DTR in the high byte
   dzLineMask_t lineEnable;
   dzLineMask_t dtr;

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         lineEnable <= '0;
         dtr        <= '0;
      end
      else if (regBus.devReset)
      begin
         lineEnable <= '0;
         dtr        <= '0;
      end
      else if (regBus.tcrWrite)
      begin
         // Each lane on its own
         if (regBus.loByte)
         begin
            lineEnable <= regBus.data[`DZ_TCR_LIN];
         end
         if (regBus.hiByte)
         begin
            dtr <= regBus.data[`DZ_TCR_DTR];
         end
      end
   end

   assign regTcr = {dtr, lineEnable};

endmodule

`default_nettype wire

// File: logic/dzCsr.sv
// DZ11 control and status register
`default_nettype none
`timescale 1ns/1ns

`include "dz_settings.svh"

module dzCsr (
   input  wire logic               clk,
   input  wire logic               rst,
   dzRegBus.register               regBus,
   input  wire dzPkg::dzWord_t     regTcr,
   input  wire dzPkg::dzLineMask_t txEmpty,
   output dzPkg::dzWord_t          regCsr
);
   import dzPkg::*;

   // Clear length in clocks, 375 at 25 MHz
   localparam int ClrCycles = (`DZ_CLK_FREQ / 1000000) * `DZ_CLR_US;
   localparam int ClrWidth  = $clog2(ClrCycles + 1);

   typedef enum logic [1:0]
   {
      stScan,
      stHold,
      stWait
   } scanState_t;

   dzLineMask_t          lineEnable;
   logic [ClrWidth-1:0]  clrCount;
   logic                 clrActive;
   logic                 clrStart;
   logic                 wipe;
   logic                 tdrLoad;

   // Read/write bits
   logic                 tie;
   logic                 sae;
   logic                 rie;
   logic                 mse;
   logic                 maint;

   // Scanner
   scanState_t           state;
   dzLine_t              scanPos;
   dzLine_t              tLine;

   assign lineEnable = regTcr[`DZ_TCR_LIN];
   assign tdrLoad    = regBus.tdrWrite & regBus.loByte;

   ////////////////////////////////////////////////////////////////////////////
   // Clear one-shot
   ////////////////////////////////////////////////////////////////////////////

   // Low byte write with CLR set
   assign clrStart  = regBus.csrWrite & regBus.loByte & regBus.data[`DZ_CSR_CLR];
   assign clrActive = (clrCount != '0);

   // Everything below is held clear by any of these
   assign wipe = regBus.devReset | clrStart | clrActive;

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         clrCount <= '0;
      end
      else if (regBus.devReset)
      begin
         clrCount <= '0;
      end
      else if (clrStart)
      begin
         clrCount <= ClrWidth'(ClrCycles);
      end
      else if (clrActive)
      begin
         clrCount <= clrCount - 1'b1;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Read/write bits, per lane
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         tie   <= 1'b0;
         sae   <= 1'b0;
         rie   <= 1'b0;
         mse   <= 1'b0;
         maint <= 1'b0;
      end
      else if (wipe)
      begin
         tie   <= 1'b0;
         sae   <= 1'b0;
         rie   <= 1'b0;
         mse   <= 1'b0;
         maint <= 1'b0;
      end
      else if (regBus.csrWrite)
      begin
         if (regBus.hiByte)
         begin
            tie <= regBus.data[`DZ_CSR_TIE];
            sae <= regBus.data[`DZ_CSR_SAE];
         end
         if (regBus.loByte)
         begin
            rie   <= regBus.data[`DZ_CSR_RIE];
            mse   <= regBus.data[`DZ_CSR_MSE];
            maint <= regBus.data[`DZ_CSR_MAINT];
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Transmit scanner
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         state   <= stScan;
         scanPos <= '0;
         tLine   <= '0;
      end
      else if (wipe)
      begin
         state   <= stScan;
         scanPos <= '0;
         tLine   <= '0;
      end
      else
      begin
         case (state)
            // One line per clock, stop on enabled and empty
            stScan:
            begin
               if (mse)
               begin
                  if (lineEnable[scanPos] & txEmpty[scanPos])
                  begin
                     tLine <= scanPos;
                     state <= stHold;
                  end
                  else
                  begin
                     scanPos <= scanPos + 1'b1;
                  end
               end
            end
            // Offer TLINE until loaded, or drop it if disabled
            stHold:
            begin
               if (!lineEnable[tLine])
               begin
                  state <= stScan;
               end
               else if (tdrLoad)
               begin
                  state <= stWait;
               end
            end
            // Let the write strobe go away first
            stWait:
            begin
               if (!tdrLoad)
               begin
                  state <= stScan;
               end
            end
            default:
            begin
               state <= stScan;
            end
         endcase
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // CSR word
   ////////////////////////////////////////////////////////////////////////////

   always_comb
   begin
      regCsr                 = '0;
      regCsr[`DZ_CSR_TRDY]   = (state != stScan);
      regCsr[`DZ_CSR_TIE]    = tie;
      // No silo, so no alarm
      regCsr[`DZ_CSR_SA]     = 1'b0;
      regCsr[`DZ_CSR_SAE]    = sae;
      regCsr[`DZ_CSR_TLINE]  = tLine;
      // No receiver
      regCsr[`DZ_CSR_RDONE]  = 1'b0;
      regCsr[`DZ_CSR_RIE]    = rie;
      regCsr[`DZ_CSR_MSE]    = mse;
      regCsr[`DZ_CSR_CLR]    = clrActive;
      regCsr[`DZ_CSR_MAINT]  = maint;
   end

endmodule

`default_nettype wire

// File: logic/dzTxLines.sv
// DZ11 serial transmitters
`default_nettype none
`timescale 1ns/1ns

`include "dz_settings.svh"

module dzTxLines (
   input  wire logic               clk,
   input  wire logic               rst,
   dzRegBus.register               regBus,
   input  wire dzPkg::dzWord_t     regCsr,
   output wire dzPkg::dzLineMask_t txEmpty,
   output wire dzPkg::dzLineMask_t txd
);
   import dzPkg::*;

   // Start, eight data, stop
   localparam int FrameBits  = 10;
   localparam int BitCycles  = `DZ_BIT_CYCLES;
   localparam int CycleWidth = $clog2(BitCycles);
   localparam int BitWidth   = $clog2(FrameBits + 1);

   logic       tdrLoad;
   dzLine_t    selLine;
   logic [7:0] txChar;

   // Only taken while the scanner offers a line
   assign tdrLoad = regBus.tdrWrite & regBus.loByte & regCsr[`DZ_CSR_TRDY];
   assign selLine = regCsr[`DZ_CSR_TLINE];
   assign txChar  = regBus.data[7:0];

   for (genvar i = 0; i < `DZ_LINES; i++)
   begin : gLine
      logic [FrameBits-1:0]  shiftReg;
      logic [BitWidth-1:0]   bitsLeft;
      logic [CycleWidth-1:0] cycleCount;
      logic                  load;

      assign load = tdrLoad & (selLine == dzLine_t'(i));

      always_ff @(posedge clk or posedge rst)
      begin
         if (rst)
         begin
            shiftReg   <= '1;
            bitsLeft   <= '0;
            cycleCount <= '0;
         end
         else if (regBus.devReset)
         begin
            // Abort, line back to mark
            shiftReg   <= '1;
            bitsLeft   <= '0;
            cycleCount <= '0;
         end
         else if (load)
         begin
            // Start bit goes out on this edge
            shiftReg   <= {1'b1, txChar, 1'b0};
            bitsLeft   <= BitWidth'(FrameBits);
            cycleCount <= CycleWidth'(BitCycles - 1);
         end
         else if (bitsLeft != '0)
         begin
            if (cycleCount == '0)
            begin
               // Next bit, LSB first, mark fills in behind
               shiftReg   <= {1'b1, shiftReg[FrameBits-1:1]};
               bitsLeft   <= bitsLeft - 1'b1;
               cycleCount <= CycleWidth'(BitCycles - 1);
            end
            else
            begin
               cycleCount <= cycleCount - 1'b1;
            end
         end
      end

      assign txd[i]     = shiftReg[0];
      assign txEmpty[i] = (bitsLeft == '0);
   end

endmodule

`default_nettype wire

// File: logic/dz11.sv
// DZ11 multiplexer top level
`default_nettype none
`timescale 1ns/1ns

module dz11 (
   input  wire logic               clk,
   input  wire logic               rst,
   input  wire logic               devReset,
   input  wire dzPkg::dzAddr_t     busAddr,
   input  wire logic               busWrite,
   input  wire logic               loByte,
   input  wire logic               hiByte,
   input  wire dzPkg::dzWord_t     dataIn,
   output wire dzPkg::dzWord_t     dataOut,
   output wire dzPkg::dzLineMask_t txd
);
   import dzPkg::*;

   dzWord_t     regCsr;
   dzWord_t     regTcr;
   wire dzLineMask_t txEmpty;

   // Decoded strobes to the registers
   dzRegBus regBus ();

   // Address decode and read mux
   dzBusDecode iDecode (
      .busAddr  (busAddr),
      .busWrite (busWrite),
      .loByte   (loByte),
      .hiByte   (hiByte),
      .dataIn   (dataIn),
      .devReset (devReset),
      .regCsr   (regCsr),
      .regTcr   (regTcr),
      .dataOut  (dataOut),
      .regBus   (regBus.decoder)
   );

   // Line enables and DTR
   dzTcr iTcr (
      .clk    (clk),
      .rst    (rst),
      .regBus (regBus.register),
      .regTcr (regTcr)
   );

   // CSR, clear one-shot and scanner
   dzCsr iCsr (
      .clk     (clk),
      .rst     (rst),
      .regBus  (regBus.register),
      .regTcr  (regTcr),
      .txEmpty (txEmpty),
      .regCsr  (regCsr)
   );

   // Serial outputs
   dzTxLines iTxLines (
      .clk     (clk),
      .rst     (rst),
      .regBus  (regBus.register),
      .regCsr  (regCsr),
      .txEmpty (txEmpty),
      .txd     (txd)
   );

endmodule

`default_nettype wire

// File: sim/dzTb.sv
// DZ11 directed testbench
`default_nettype none
`timescale 1ns/1ns

`include "dz_settings.svh"

module dzTb;
   import dzPkg::*;

   // Limit summed from the test lengths with a wide margin
   localparam int TimeoutCycles = 20000;
   localparam int BitCycles     = `DZ_BIT_CYCLES;
   // Clear one-shot is 15 us at 25 MHz
   localparam int ClrCycles     = 375;

   // CSR bit groups
   localparam dzWord_t CsrRwMask = dzWord_t'((1 << `DZ_CSR_TIE) | (1 << `DZ_CSR_SAE) |
      (1 << `DZ_CSR_RIE) | (1 << `DZ_CSR_MSE) | (1 << `DZ_CSR_MAINT));
   localparam dzWord_t MseBit    = dzWord_t'(1 << `DZ_CSR_MSE);
   localparam dzWord_t ClrBit    = dzWord_t'(1 << `DZ_CSR_CLR);

   logic        clk = 1'b0;
   logic        rst;
   logic        devReset;
   dzAddr_t     busAddr;
   logic        busWrite;
   logic        loByte;
   logic        hiByte;
   dzWord_t     dataIn;
   dzWord_t     dataOut;
   dzLineMask_t txd;

   logic [15:0] lfsrState  = 16'd20389;
   int          cycleCount = 0;
   int          checkCount = 0;
   int          errorCount = 0;

   // 40 ns clock
   always #20 clk = ~clk;

   dz11 i_dut (
      .clk      (clk),
      .rst      (rst),
      .devReset (devReset),
      .busAddr  (busAddr),
      .busWrite (busWrite),
      .loByte   (loByte),
      .hiByte   (hiByte),
      .dataIn   (dataIn),
      .dataOut  (dataOut),
      .txd      (txd)
   );

   // Run limit
   always @(posedge clk)
   begin
      cycleCount <= cycleCount + 1;
      if (cycleCount >= TimeoutCycles)
      begin
         $display("ERROR: run did not finish within %0d cycles", TimeoutCycles);
         $display("TEST FAIL");
         $finish;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Random bits and checks
   ////////////////////////////////////////////////////////////////////////////

   // Galois LFSR with taps x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] galoisStep(input logic [15:0] state);
      logic [15:0] next;
      next = state >> 1;
      if (state[0])
      begin
         next = next ^ 16'hB400;
      end
      return next;
   endfunction

   // One step per bit taken
   function automatic logic [15:0] takeBits(input int count);
      logic [15:0] bits;
      bits = '0;
      for (int i = 0; i < count; i++)
      begin
         bits      = {bits[14:0], lfsrState[0]};
         lfsrState = galoisStep(lfsrState);
      end
      return bits;
   endfunction

   task automatic checkValue(input string name, input logic [15:0] got,
                             input logic [15:0] expected);
      checkCount++;
      assert (got === expected)
      else
      begin
         errorCount++;
         $display("[FAIL] %0t ns %s: got %h, expected %h", $time, name, got, expected);
      end
   endtask

   task automatic checkTrue(input logic ok, input string what);
      checkCount++;
      assert (ok)
      else
      begin
         errorCount++;
         $display("ERROR: %0t ns %s", $time, what);
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Bus access
   ////////////////////////////////////////////////////////////////////////////

   // One-cycle write strobe with lanes held only while it is high
   task automatic writeReg(input dzAddr_t addr, input dzWord_t data,
                           input logic lo, input logic hi);
      @(negedge clk);
      busAddr  = addr;
      dataIn   = data;
      loByte   = lo;
      hiByte   = hi;
      busWrite = 1'b1;
      @(negedge clk);
      busWrite = 1'b0;
      loByte   = 1'b0;
      hiByte   = 1'b0;
   endtask

   // Read mux is combinational
   task automatic readNow(input dzAddr_t addr, output dzWord_t data);
      busAddr = addr;
      #1;
      data = dataOut;
   endtask

   task automatic readReg(input dzAddr_t addr, output dzWord_t data);
      @(negedge clk);
      readNow(addr, data);
   endtask

   task automatic pulseDevReset();
      @(negedge clk);
      devReset = 1'b1;
      @(negedge clk);
      devReset = 1'b0;
   endtask

   // Poll TRDY once per cycle until it shows level
   task automatic waitTrdyLevel(input logic level, input int maxCycles,
                                output dzWord_t csr, output logic found);
      found = 1'b0;
      csr   = '0;
      for (int i = 0; i < maxCycles && !found; i++)
      begin
         readReg(regCsr, csr);
         found = (csr[`DZ_CSR_TRDY] == level);
      end
   endtask

   // First enabled line at or after pos with wrap at the line count
   function automatic int nextEnabled(input int pos, input dzLineMask_t enables);
      int      line;
      dzLine_t idx;
      line = -1;
      for (int i = `DZ_LINES - 1; i >= 0; i--)
      begin
         idx = dzLine_t'(pos + i);
         if (enables[idx])
         begin
            line = int'(idx);
         end
      end
      return line;
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // Frame capture
   ////////////////////////////////////////////////////////////////////////////

   // Idle lines stay at mark and the busy line is never offered
   task automatic checkDuringFrame(input dzLine_t line);
      dzLineMask_t others;
      others = txd | dzLineMask_t'(1 << line);
      checkValue("txd other lines", 16'(others), 16'h00FF);
      if (busAddr == regCsr)
      begin
         checkTrue(!(dataOut[`DZ_CSR_TRDY] && dataOut[`DZ_CSR_TLINE] == line),
                   "scanner offered a line whose frame is still running");
      end
   endtask

   task automatic captureFrame(input dzLine_t line, input int maxWait,
                               output logic [7:0] ch);
      int waited;
      waited = 0;
      ch     = '0;
      // Start bit edge is seen half a cycle late
      @(negedge clk);
      while (txd[line] !== 1'b0 && waited < maxWait)
      begin
         @(negedge clk);
         waited++;
      end
      checkTrue(txd[line] === 1'b0, $sformatf("no start bit on line %0d", line));
      // Middle of the start bit
      repeat (BitCycles / 2 - 1) @(negedge clk);
      checkValue("txd start bit", 16'(txd[line]), 16'h0000);
      checkDuringFrame(line);
      // Data bits LSB first
      for (int b = 0; b < 8; b++)
      begin
         repeat (BitCycles) @(negedge clk);
         ch = {txd[line], ch[7:1]};
         checkDuringFrame(line);
      end
      repeat (BitCycles) @(negedge clk);
      checkValue("txd stop bit", 16'(txd[line]), 16'h0001);
      checkDuringFrame(line);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Tests
   ////////////////////////////////////////////////////////////////////////////

   task automatic testReset();
      dzWord_t value;
      readReg(regCsr, value);
      checkValue("CSR", value, 16'h0000);
      readReg(regRbuf, value);
      checkValue("RBUF", value, 16'h0000);
      readReg(regTcr, value);
      checkValue("TCR", value, 16'h0000);
      readReg(regTdr, value);
      checkValue("MSR", value, 16'h0000);
      checkValue("txd", 16'(txd), 16'h00FF);
      // Load both then pulse device reset
      writeReg(regTcr, 16'hA55A, 1'b1, 1'b1);
      writeReg(regCsr, CsrRwMask & ~MseBit, 1'b1, 1'b1);
      readReg(regTcr, value);
      checkValue("TCR", value, 16'hA55A);
      readReg(regCsr, value);
      checkValue("CSR", value, CsrRwMask & ~MseBit);
      pulseDevReset();
      readReg(regTcr, value);
      checkValue("TCR after devReset", value, 16'h0000);
      readReg(regCsr, value);
      checkValue("CSR after devReset", value, 16'h0000);
   endtask

   task automatic testByteLanes();
      dzWord_t csrModel;
      dzWord_t tcrModel;
      dzWord_t csrData;
      dzWord_t tcrData;
      dzWord_t value;
      logic    lo;
      logic    hi;
      csrModel = '0;
      tcrModel = '0;
      for (int pass = 0; pass < 3; pass++)
      begin
         // High lane then low lane then both
         hi = (pass != 1);
         lo = (pass != 0);
         // MSE and CLR kept out so scanner and clear stay idle
         csrData = takeBits(16) & ~(ClrBit | MseBit);
         tcrData = takeBits(16);
         writeReg(regCsr, csrData, lo, hi);
         writeReg(regTcr, tcrData, lo, hi);
         if (hi)
         begin
            csrModel[15:8] = csrData[15:8];
            tcrModel[15:8] = tcrData[15:8];
         end
         if (lo)
         begin
            csrModel[7:0] = csrData[7:0];
            tcrModel[7:0] = tcrData[7:0];
         end
         readReg(regCsr, value);
         checkValue("CSR", value, csrModel & CsrRwMask);
         checkValue("CSR TRDY", 16'(value[`DZ_CSR_TRDY]), 16'h0000);
         readReg(regTcr, value);
         checkValue("TCR", value, tcrModel);
      end
   endtask

   task automatic testScanner(output dzLine_t heldLine);
      dzWord_t csr;
      logic    found;
      dzLine_t k;
      dzLine_t j;
      k = dzLine_t'(takeBits(3));
      j = dzLine_t'(takeBits(3));
      while (j == k)
      begin
         j = dzLine_t'(takeBits(3));
      end
      writeReg(regTcr, 16'(1 << k), 1'b1, 1'b1);
      writeReg(regCsr, MseBit, 1'b1, 1'b0);
      waitTrdyLevel(1'b1, 10, csr, found);
      checkTrue(found, "TRDY did not rise with one line enabled");
      checkValue("CSR TLINE", 16'(csr[`DZ_CSR_TLINE]), 16'(k));
      // Move the enable from k to j
      writeReg(regTcr, 16'(1 << j), 1'b1, 1'b0);
      waitTrdyLevel(1'b0, 2, csr, found);
      checkTrue(found, "TRDY stayed set after its line was disabled");
      waitTrdyLevel(1'b1, 10, csr, found);
      checkTrue(found, "TRDY did not rise for the newly enabled line");
      checkValue("CSR TLINE", 16'(csr[`DZ_CSR_TLINE]), 16'(j));
      heldLine = j;
   endtask

   task automatic testTransmit(input dzLine_t line);
      dzWord_t    csr;
      logic       found;
      logic [7:0] txChar;
      logic [7:0] received;
      txChar = 8'(takeBits(8));
      fork
         captureFrame(line, 20, received);
         begin
            writeReg(regTdr, {8'h00, txChar}, 1'b1, 1'b0);
            // CSR on the read mux while the frame runs
            busAddr = regCsr;
         end
      join
      checkValue("received character", 16'(received), 16'(txChar));
      // Empty again so offered again
      waitTrdyLevel(1'b1, 30, csr, found);
      checkTrue(found, "line not offered again after its frame");
      checkValue("CSR TLINE", 16'(csr[`DZ_CSR_TLINE]), 16'(line));
   endtask

   task automatic testRoundRobin();
      dzWord_t     csr;
      dzLineMask_t enables;
      logic        found;
      int          expected;
      int          pos;
      // Scanner back to line 0
      pulseDevReset();
      enables = dzLineMask_t'(takeBits(8));
      while ($countones(enables) < 2)
      begin
         enables = dzLineMask_t'(takeBits(8));
      end
      writeReg(regTcr, {8'h00, enables}, 1'b1, 1'b1);
      writeReg(regCsr, MseBit, 1'b1, 1'b0);
      pos = 0;
      for (int n = 0; n < 6; n++)
      begin
         expected = nextEnabled(pos, enables);
         waitTrdyLevel(1'b1, 200, csr, found);
         checkTrue(found, "TRDY did not rise during round robin");
         checkValue("CSR TLINE", 16'(csr[`DZ_CSR_TLINE]), 16'(expected));
         writeReg(regTdr, {8'h00, 8'(takeBits(8))}, 1'b1, 1'b0);
         // Just loaded and busy while older frames end in load order
         pos = (expected + 1) % `DZ_LINES;
      end
   endtask

   task automatic testClear();
      dzWord_t value;
      logic    found;
      writeReg(regCsr, CsrRwMask, 1'b1, 1'b1);
      waitTrdyLevel(1'b1, 200, value, found);
      checkTrue(found, "TRDY did not rise before the clear");
      writeReg(regCsr, ClrBit | CsrRwMask, 1'b1, 1'b0);
      // Cycle 0 after the strobe
      readNow(regCsr, value);
      checkValue("CSR right after CLR", value, ClrBit);
      // Last cycles of the one-shot
      repeat (ClrCycles - 1) @(negedge clk);
      readNow(regCsr, value);
      checkValue("CSR near end of clear", value, ClrBit);
      repeat (2) @(negedge clk);
      readNow(regCsr, value);
      checkValue("CSR after clear", value, 16'h0000);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Sequence
   ////////////////////////////////////////////////////////////////////////////

   initial
   begin
      dzLine_t heldLine;
      rst      = 1'b1;
      devReset = 1'b0;
      busAddr  = regCsr;
      busWrite = 1'b0;
      loByte   = 1'b0;
      hiByte   = 1'b0;
      dataIn   = '0;
      // Eight cycles of reset
      repeat (8) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      testReset();
      testByteLanes();
      testScanner(heldLine);
      testTransmit(heldLine);
      testRoundRobin();
      testClear();

      $display("Checks: %0d, errors: %0d", checkCount, errorCount);
      if (errorCount == 0)
      begin
         $display("TEST PASS");
      end
      else
      begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+logic
logic/dzPkg.sv
logic/dzRegBus.sv
logic/dzBusDecode.sv
logic/dzTcr.sv
logic/dzCsr.sv
logic/dzTxLines.sv
logic/dz11.sv
sim/dzTb.sv

// File: Makefile
# DZ11 simulation with Verilator

BUILD = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert --timing -f verilog.f --top-module dzTb \
		-Mdir $(BUILD) -o dzSim

run: compile
	./$(BUILD)/dzSim | tee sim.log
	grep -q "^TEST PASS$$" sim.log

clean:
	rm -rf $(BUILD) sim.log
